// ==== hdl/emu_cfg_pkg.sv ====
`default_nettype none

package emu_cfg_pkg;

    // host commands, decoded in emu_ctrl
    typedef enum logic [1:0] {
        CMD_NOP    = 2'd0,
        CMD_RUN    = 2'd1,
        CMD_PAUSE  = 2'd2,
        CMD_RESUME = 2'd3
    } emu_cmd_e;

    // count of fired target cycles
    typedef logic [31:0] cycle_t;

    typedef logic [15:0] scan_word_t;

endpackage

`default_nettype wire

// ==== hdl/target_pkg.sv ====
`default_nettype none

package target_pkg;

    // ram word: marker on top, addend below it
    typedef logic [15:0] data_t;

    typedef logic [31:0] acc_t;

    typedef logic [7:0] ptr_t;

    localparam int unsigned MARK_BIT = 15;

endpackage

`default_nettype wire

// ==== hdl/clock_gate.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gate (
    input  wire  clk,
    input  wire  en,
    output logic gclk
);

    logic en_lat;

    // transparent while clk is low, so en is stable across the high phase
    always_latch begin
        if (!clk) begin
            en_lat <= en;
        end
    end

    assign gclk = clk & en_lat;

endmodule

`default_nettype wire

// ==== hdl/emu_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module emu_ctrl (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        cmd_valid,
    input  wire emu_cfg_pkg::emu_cmd_e cmd_op,
    input  wire emu_cfg_pkg::cycle_t   cmd_arg,
    input  wire                        ff_scan,
    input  wire                        ram_scan,
    input  wire                        emit_req,
    input  wire target_pkg::acc_t      trace_value,
    input  wire                        trace_pop,
    output logic                       core_clk_en,
    output logic                       ff_clk_en,
    output logic                       ram_clk_en,
    output logic                       running,
    output emu_cfg_pkg::cycle_t        cycle_count,
    output logic                       trace_valid,
    output target_pkg::acc_t           trace_data
);

    import emu_cfg_pkg::*;

    logic   paused;
    cycle_t budget;
    logic   stall;
    logic   fire;
    logic   ram_scan_q;

    // full slot holds the target on a marker word until the host pops it
    assign stall   = emit_req && trace_valid;
    assign running = !paused && (budget != '0);
    assign fire    = running && !ff_scan && !ram_scan && !stall;

    // enables forced on in reset so the gated flops see rst_n
    assign core_clk_en = fire || !rst_n;
    assign ff_clk_en   = fire || ff_scan || !rst_n;
    // one extra ram edge after a scan returns the scan address to zero
    assign ram_clk_en  = fire || ram_scan || ram_scan_q || !rst_n;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            paused <= 1'b1;
        end else if (cmd_valid) begin
            case (cmd_op)
                CMD_RUN, CMD_RESUME: paused <= 1'b0;
                CMD_PAUSE:           paused <= 1'b1;
                default:             paused <= paused;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            budget <= '0;
        end else if (cmd_valid && (cmd_op == CMD_RUN)) begin
            budget <= cmd_arg;
        end else if (fire) begin
            budget <= budget - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_count <= '0;
        end else if (fire) begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ram_scan_q <= 1'b0;
        end else begin
            ram_scan_q <= ram_scan;
        end
    end

    // a load wins over a pop in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            trace_valid <= 1'b0;
        end else if (fire && emit_req) begin
            trace_valid <= 1'b1;
        end else if (trace_pop) begin
            trace_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire && emit_req) begin
            trace_data <= trace_value;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/target_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module target_core (
    input  wire                          ff_clk,
    input  wire                          rst_n,
    input  wire target_pkg::data_t       ram_data,
    input  wire                          ff_scan,
    input  wire                          ff_dir,
    input  wire emu_cfg_pkg::scan_word_t ff_sdi,
    output target_pkg::ptr_t             ram_addr,
    output logic                         emit_req,
    output target_pkg::acc_t             trace_value,
    output emu_cfg_pkg::scan_word_t      ff_sdo
);

    import target_pkg::*;
    import emu_cfg_pkg::*;

    localparam int unsigned WORD_W = $bits(scan_word_t);
    localparam int unsigned ACC_W  = $bits(acc_t);
    localparam int unsigned PTR_W  = $bits(ptr_t);

    acc_t       acc;
    // pointer lives in the low byte, the high byte is zero outside a scan
    scan_word_t ptr_word;
    scan_word_t scan_in;
    acc_t       addend;
    ptr_t       ptr_next;

    assign ram_addr    = ptr_word[PTR_W-1:0];
    assign ptr_next    = ram_addr + 1'b1;
    assign emit_req    = ram_data[MARK_BIT];
    assign addend      = acc_t'(ram_data[MARK_BIT-1:0]);
    assign trace_value = acc + addend;

    // chain order is sdi -> acc high -> acc low -> pointer word -> sdo
    assign ff_sdo  = ptr_word;
    assign scan_in = ff_dir ? ff_sdi : ff_sdo;

    // ff_clk only ticks on fire, scan or reset, so no extra enable here
    always_ff @(posedge ff_clk) begin
        if (!rst_n) begin
            acc      <= '0;
            ptr_word <= '0;
        end else if (ff_scan) begin
            acc      <= {scan_in, acc[ACC_W-1 -: WORD_W]};
            ptr_word <= acc[WORD_W-1:0];
        end else begin
            acc      <= trace_value;
            ptr_word <= scan_word_t'(ptr_next);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/target_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module target_ram #(
    parameter int unsigned RAM_DEPTH = 256
) (
    input  wire                    ram_clk,
    input  wire                    rst_n,
    input  wire target_pkg::ptr_t  ram_addr,
    input  wire                    ram_scan,
    input  wire                    ram_dir,
    input  wire target_pkg::data_t ram_sdi,
    output target_pkg::data_t      ram_data,
    output target_pkg::data_t      ram_sdo
);

    import target_pkg::*;

    localparam int unsigned ADDR_W = (RAM_DEPTH > 1) ? $clog2(RAM_DEPTH) : 1;

    data_t             mem [RAM_DEPTH];
    logic [ADDR_W-1:0] scan_addr;
    logic [ADDR_W-1:0] core_idx;

    // pointer wraps modulo the depth
    assign core_idx = ram_addr[ADDR_W-1:0];

    assign ram_data = mem[core_idx];
    assign ram_sdo  = mem[scan_addr];

    // restarts from zero on the first edge without scan
    always_ff @(posedge ram_clk) begin
        if (!rst_n) begin
            scan_addr <= '0;
        end else if (ram_scan) begin
            scan_addr <= scan_addr + 1'b1;
        end else begin
            scan_addr <= '0;
        end
    end

    always_ff @(posedge ram_clk) begin
        if (ram_scan && ram_dir) begin
            mem[scan_addr] <= ram_sdi;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/emu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module emu_top #(
    parameter int unsigned RAM_DEPTH = 256
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          cmd_valid,
    input  wire emu_cfg_pkg::emu_cmd_e   cmd_op,
    input  wire emu_cfg_pkg::cycle_t     cmd_arg,
    input  wire                          trace_pop,
    input  wire                          ff_scan,
    input  wire                          ff_dir,
    input  wire emu_cfg_pkg::scan_word_t ff_sdi,
    input  wire                          ram_scan,
    input  wire                          ram_dir,
    input  wire target_pkg::data_t       ram_sdi,
    output wire emu_cfg_pkg::scan_word_t ff_sdo,
    output wire target_pkg::data_t       ram_sdo,
    output wire                          running,
    output wire emu_cfg_pkg::cycle_t     cycle_count,
    output wire                          trace_valid,
    output wire target_pkg::acc_t        trace_data
);

    import target_pkg::*;

    wire        core_clk_en;
    wire        ff_clk_en;
    wire        ram_clk_en;
    wire        ff_clk;
    wire        ram_clk;
    wire        emit_req;
    wire acc_t  trace_value;
    wire ptr_t  ram_addr;
    wire data_t ram_data;

    emu_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_arg     (cmd_arg),
        .ff_scan     (ff_scan),
        .ram_scan    (ram_scan),
        .emit_req    (emit_req),
        .trace_value (trace_value),
        .trace_pop   (trace_pop),
        .core_clk_en (core_clk_en),
        .ff_clk_en   (ff_clk_en),
        .ram_clk_en  (ram_clk_en),
        .running     (running),
        .cycle_count (cycle_count),
        .trace_valid (trace_valid),
        .trace_data  (trace_data)
    );

    // core-only clock, no loads in the current target
    clock_gate u_core_gate (
        .clk  (clk),
        .en   (core_clk_en),
        .gclk ()
    );

    clock_gate u_ff_gate (
        .clk  (clk),
        .en   (ff_clk_en),
        .gclk (ff_clk)
    );

    clock_gate u_ram_gate (
        .clk  (clk),
        .en   (ram_clk_en),
        .gclk (ram_clk)
    );

    target_core u_core (
        .ff_clk      (ff_clk),
        .rst_n       (rst_n),
        .ram_data    (ram_data),
        .ff_scan     (ff_scan),
        .ff_dir      (ff_dir),
        .ff_sdi      (ff_sdi),
        .ram_addr    (ram_addr),
        .emit_req    (emit_req),
        .trace_value (trace_value),
        .ff_sdo      (ff_sdo)
    );

    target_ram #(
        .RAM_DEPTH (RAM_DEPTH)
    ) u_ram (
        .ram_clk  (ram_clk),
        .rst_n    (rst_n),
        .ram_addr (ram_addr),
        .ram_scan (ram_scan),
        .ram_dir  (ram_dir),
        .ram_sdi  (ram_sdi),
        .ram_data (ram_data),
        .ram_sdo  (ram_sdo)
    );

endmodule

`default_nettype wire

// ==== tests/tb_emu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_emu_top;

    import emu_cfg_pkg::*;
    import target_pkg::*;

    localparam int unsigned RAM_DEPTH = 256;
    // full ram load is about 260 cycles, everything together stays under 800
    localparam int unsigned TIMEOUT_CYCLES = 4000;

    logic       clk;
    logic       rst_n;
    logic       cmd_valid;
    emu_cmd_e   cmd_op;
    cycle_t     cmd_arg;
    logic       trace_pop;
    logic       ff_scan;
    logic       ff_dir;
    scan_word_t ff_sdi;
    logic       ram_scan;
    logic       ram_dir;
    data_t      ram_sdi;
    scan_word_t ff_sdo;
    data_t      ram_sdo;
    logic       running;
    cycle_t     cycle_count;
    logic       trace_valid;
    acc_t       trace_data;

    // reference model of the target
    data_t  ram_model [RAM_DEPTH];
    acc_t   acc_model = '0;
    ptr_t   ptr_model = '0;
    cycle_t cycles_model = '0;

    string  test_name;
    int     errors = 0;
    int     failed_tests = 0;
    int     test_errors = 0;
    int     clk_count = 0;

    emu_top #(
        .RAM_DEPTH (RAM_DEPTH)
    ) u_emu_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        clk_count++;
        if (clk_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check_data(input string what, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_acc(input string what, input acc_t exp, input acc_t act);
        if (act !== exp) begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_cycle(input string what, input cycle_t exp, input cycle_t act);
        if (act !== exp) begin
            $display("ERROR %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_scan(input string what, input scan_word_t exp, input scan_word_t act);
        if (act !== exp) begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        if (errors == test_errors) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors - test_errors);
            failed_tests++;
        end
    endtask

    // advance the model by n fired cycles
    task automatic model_step(input int n);
        repeat (n) begin
            acc_model = acc_model + acc_t'(ram_model[ptr_model] & 16'h7fff);
            ptr_model = ptr_model + 1'b1;
        end
        cycles_model = cycles_model + cycle_t'(n);
    endtask

    task automatic send_cmd(input emu_cmd_e op, input cycle_t arg);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_op    <= op;
        cmd_arg   <= arg;
        @(posedge clk);
        cmd_valid <= 1'b0;
        cmd_op    <= CMD_NOP;
    endtask

    task automatic pop_trace();
        @(posedge clk);
        trace_pop <= 1'b1;
        @(posedge clk);
        trace_pop <= 1'b0;
    endtask

    // checked at falling edges, gives up after 200 cycles
    task automatic wait_until(input string what, input cycle_t count_target);
        int   n;
        logic done;
        n    = 0;
        done = 1'b0;
        while (!done && n < 200) begin
            @(negedge clk);
            n++;
            case (what)
                "idle":  done = !running;
                "trace": done = trace_valid;
                "empty": done = !trace_valid;
                default: done = (cycle_count == count_target);
            endcase
        end
        if (!done) begin
            $display("%s: gave up waiting for %s after %0d cycles", test_name, what, n);
            errors++;
        end
    endtask

    // scan address starts at zero and steps once per clock
    task automatic ram_scan_words(input logic dir, input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            ram_scan <= 1'b1;
            ram_dir  <= dir;
            ram_sdi  <= ram_model[i];
            if (!dir) begin
                @(negedge clk);
                check_data($sformatf("ram word %0d", i), ram_model[i], ram_sdo);
            end
        end
        @(posedge clk);
        ram_scan <= 1'b0;
        ram_dir  <= 1'b0;
        // one more edge lets the scan address fall back to zero
        @(posedge clk);
    endtask

    // three chain shifts, recirculating when dir is low
    task automatic ff_shift(input logic dir, input scan_word_t w0, w1, w2,
                            output scan_word_t r0, r1, r2);
        scan_word_t w_in [3];
        scan_word_t w_out [3];
        w_in = '{w0, w1, w2};
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            ff_scan <= 1'b1;
            ff_dir  <= dir;
            ff_sdi  <= w_in[i];
            @(negedge clk);
            w_out[i] = ff_sdo;
        end
        @(posedge clk);
        ff_scan <= 1'b0;
        ff_dir  <= 1'b0;
        r0 = w_out[0];
        r1 = w_out[1];
        r2 = w_out[2];
    endtask

    task automatic check_state(input string tag);
        scan_word_t p, lo, hi;
        ff_shift(1'b0, '0, '0, '0, p, lo, hi);
        check_scan({tag, " ptr word"}, {8'h00, ptr_model}, p);
        check_scan({tag, " acc low"}, acc_model[15:0], lo);
        check_scan({tag, " acc high"}, acc_model[31:16], hi);
    endtask

    task automatic test_ram_scan();
        begin_test("ram_scan_round_trip");
        for (int i = 0; i < 16; i++) begin
            ram_model[i] = data_t'($urandom);
        end
        ram_scan_words(1'b1, 16);
        ram_scan_words(1'b0, 16);
        end_test();
    endtask

    task automatic test_run_budget();
        begin_test("run_budget");
        for (int i = 0; i < RAM_DEPTH; i++) begin
            ram_model[i] = data_t'($urandom) & 16'h7fff;
        end
        ram_scan_words(1'b1, RAM_DEPTH);
        send_cmd(CMD_RUN, 32'd10);
        wait_until("idle", '0);
        model_step(10);
        check_cycle("cycle_count", cycles_model, cycle_count);
        check_state("first scan");
        check_state("second scan");
        end_test();
    endtask

    task automatic test_trace_stall();
        cycle_t stall_count;
        acc_t   first_value;
        acc_t   second_value;
        int     m1;
        int     m2;
        begin_test("trace_and_stall");
        m1 = int'(ptr_model) + 3;
        m2 = int'(ptr_model) + 7;
        ram_model[m1] = ram_model[m1] | 16'h8000;
        ram_model[m2] = ram_model[m2] | 16'h8000;
        ram_scan_words(1'b1, m2 + 1);
        model_step(4);
        first_value = acc_model;
        model_step(3);
        stall_count = cycles_model;
        model_step(1);
        second_value = acc_model;
        model_step(4);
        send_cmd(CMD_RUN, 32'd12);
        wait_until("trace", '0);
        check_acc("first trace", first_value, trace_data);
        wait_until("count", stall_count);
        // the target has to hold on the second marker while the slot is full
        repeat (4) @(negedge clk);
        check_cycle("stalled count", stall_count, cycle_count);
        check_flag("running while stalled", 1'b1, running);
        check_acc("held trace", first_value, trace_data);
        pop_trace();
        wait_until("trace", '0);
        check_acc("second trace", second_value, trace_data);
        wait_until("idle", '0);
        check_cycle("final count", cycles_model, cycle_count);
        pop_trace();
        wait_until("empty", '0);
        check_state("state");
        end_test();
    endtask

    task automatic test_state_load();
        scan_word_t p, lo, hi;
        acc_t       load_acc;
        ptr_t       load_ptr;
        begin_test("state_load_by_scan");
        load_acc = 32'h0003_a5c1;
        load_ptr = 8'h30;
        // words shifted out while loading are the state left by the last test
        ff_shift(1'b1, {8'h00, load_ptr}, load_acc[15:0], load_acc[31:16], p, lo, hi);
        check_scan("old ptr word", {8'h00, ptr_model}, p);
        check_scan("old acc low", acc_model[15:0], lo);
        check_scan("old acc high", acc_model[31:16], hi);
        acc_model = load_acc;
        ptr_model = load_ptr;
        send_cmd(CMD_RUN, 32'd4);
        wait_until("idle", '0);
        model_step(4);
        check_cycle("cycle_count", cycles_model, cycle_count);
        check_state("state");
        end_test();
    endtask

    task automatic test_pause_resume();
        cycle_t frozen;
        begin_test("pause_and_resume");
        send_cmd(CMD_RUN, 32'd20);
        wait_until("count", cycles_model + 5);
        send_cmd(CMD_PAUSE, '0);
        // the edge before the strobe and the strobe's own edge still fire
        frozen = cycles_model + 7;
        @(negedge clk);
        check_cycle("count at pause", frozen, cycle_count);
        check_flag("running while paused", 1'b0, running);
        repeat (6) @(negedge clk);
        check_cycle("paused count", frozen, cycle_count);
        send_cmd(CMD_RESUME, '0);
        wait_until("idle", '0);
        model_step(20);
        check_cycle("total count", cycles_model, cycle_count);
        check_state("state");
        end_test();
    endtask

    initial begin
        void'($urandom(32'h2bfd408b));
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd_op    = CMD_NOP;
        cmd_arg   = '0;
        trace_pop = 1'b0;
        ff_scan   = 1'b0;
        ff_dir    = 1'b0;
        ff_sdi    = '0;
        ram_scan  = 1'b0;
        ram_dir   = 1'b0;
        ram_sdi   = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        test_ram_scan();
        test_run_budget();
        test_trace_stall();
        test_state_load();
        test_pause_resume();
        $display("tests run: 5, tests failed: %0d, errors: %0d", failed_tests, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/emu_cfg_pkg.sv
hdl/target_pkg.sv
hdl/clock_gate.sv
hdl/emu_ctrl.sv
hdl/target_core.sv
hdl/target_ram.sv
hdl/emu_top.sv
tests/tb_emu_top.sv

// ==== Bender.yml ====
package:
  name: emu_top

sources:
  - hdl/emu_cfg_pkg.sv
  - hdl/target_pkg.sv
  - hdl/clock_gate.sv
  - hdl/emu_ctrl.sv
  - hdl/target_core.sv
  - hdl/target_ram.sv
  - hdl/emu_top.sv
  - target: test
    files:
      - tests/tb_emu_top.sv
